// File: rab_axil_slave.sv
// RAB AXI4-Lite slave
// Accepts AW and W independently, pulses one internal write per burst-free
// transfer and returns the combined read word of the register and miss blocks

`timescale 1ns/1ps
`default_nettype none

`include "rab_cfg_settings.svh"

module rab_axil_slave
  import rab_cfg_pkg::*;
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  axi_addr_t s_axi_awaddr_i,
  input  logic      s_axi_awvalid_i,
  output logic      s_axi_awready_o,
  input  cfg_word_t s_axi_wdata_i,
  input  cfg_strb_t s_axi_wstrb_i,
  input  logic      s_axi_wvalid_i,
  output logic      s_axi_wready_o,
  output logic [1:0] s_axi_bresp_o,
  output logic      s_axi_bvalid_o,
  input  logic      s_axi_bready_i,
  input  axi_addr_t s_axi_araddr_i,
  input  logic      s_axi_arvalid_i,
  output logic      s_axi_arready_o,
  output cfg_word_t s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output logic      s_axi_rvalid_o,
  input  logic      s_axi_rready_i,
  output logic      wr_en_o,
  output word_idx_t wr_idx_o,
  output cfg_word_t wr_data_o,
  output cfg_strb_t wr_strb_o,
  output word_idx_t rd_idx_o,
  output logic      rd_pop_o,
  input  cfg_word_t regs_rdata_i,
  input  cfg_word_t mh_rdata_i
);

  localparam word_idx_t RSVD_IDX = word_idx_t'(2);  // reserved word, reads zero

  logic      aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic      aw_done_q, w_done_q;
  logic      aw_done_dly_q, w_done_dly_q;
  logic      wr_pair;
  logic      bvalid_q, rvalid_q;
  logic      aw_oor, ar_oor;
  word_idx_t wr_idx_q, rd_idx_q;
  cfg_word_t wr_data_q;
  cfg_strb_t wr_strb_q;

  // Upper address bits set or word index past the map
  function automatic logic beyond_map(input axi_addr_t addr);
    word_idx_t idx;
    idx = addr[`RAB_WORD_LSB +: `RAB_WORD_IDX_W];
    return (addr[`RAB_AXI_ADDR_W-1:`RAB_WORD_LSB+`RAB_WORD_IDX_W] != '0) ||
           (idx >= word_idx_t'(`RAB_N_WORDS));
  endfunction

  assign aw_hs  = s_axi_awvalid_i & ~aw_done_q;
  assign w_hs   = s_axi_wvalid_i & ~w_done_q;
  assign b_hs   = bvalid_q & s_axi_bready_i;
  assign ar_hs  = s_axi_arvalid_i & ~rvalid_q;
  assign r_hs   = rvalid_q & s_axi_rready_i;
  assign aw_oor = beyond_map(s_axi_awaddr_i);
  assign ar_oor = beyond_map(s_axi_araddr_i);

  // Second of the two captures happens at this edge
  assign wr_pair = (aw_hs | aw_done_q) & (w_hs | w_done_q) & ~(aw_done_q & w_done_q);

  // Write pulse from the rising edge of the capture flags
  assign wr_en_o = (aw_done_q & ~aw_done_dly_q & w_done_q) |
                   (w_done_q & ~w_done_dly_q & aw_done_q);

  // AW, W and B channels
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_done_q     <= 1'b0;
      w_done_q      <= 1'b0;
      aw_done_dly_q <= 1'b0;
      w_done_dly_q  <= 1'b0;
      bvalid_q      <= 1'b0;
    end
    else
    begin
      aw_done_dly_q <= aw_done_q;
      w_done_dly_q  <= w_done_q;
      if (aw_hs)
        aw_done_q <= 1'b1;
      else if (b_hs)
        aw_done_q <= 1'b0;  // ready again next cycle
      if (w_hs)
        w_done_q <= 1'b1;
      else if (b_hs)
        w_done_q <= 1'b0;
      if (wr_pair)
        bvalid_q <= 1'b1;
      else if (b_hs)
        bvalid_q <= 1'b0;
    end
  end

  // AR and R channels, arready is low exactly while a response is pending
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rvalid_q <= 1'b0;
    end
    else if (ar_hs)
    begin
      rvalid_q <= 1'b1;
    end
    else if (r_hs)
    begin
      rvalid_q <= 1'b0;
    end
  end

  // Captured address and data, stable until the response completes
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      wr_idx_q <= aw_oor ? RSVD_IDX : s_axi_awaddr_i[`RAB_WORD_LSB +: `RAB_WORD_IDX_W];
    if (w_hs)
    begin
      wr_data_q <= s_axi_wdata_i;
      wr_strb_q <= s_axi_wstrb_i;
    end
    if (ar_hs)
      rd_idx_q <= ar_oor ? RSVD_IDX : s_axi_araddr_i[`RAB_WORD_LSB +: `RAB_WORD_IDX_W];
  end

  assign s_axi_awready_o = ~aw_done_q;
  assign s_axi_wready_o  = ~w_done_q;
  assign s_axi_bresp_o   = 2'b00;  // always OKAY
  assign s_axi_bvalid_o  = bvalid_q;
  assign s_axi_arready_o = ~rvalid_q;
  assign s_axi_rresp_o   = 2'b00;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = regs_rdata_i | mh_rdata_i;  // each block zero outside its words

  assign wr_idx_o  = wr_idx_q;
  assign wr_data_o = wr_data_q;
  assign wr_strb_o = wr_strb_q;
  assign rd_idx_o  = rd_idx_q;
  assign rd_pop_o  = r_hs;

endmodule

`default_nettype wire

// File: rab_cfg_asserts.sv
// RAB configuration slave protocol assertions
// Response hold under back-pressure, AW stall and single-cycle write pulse

`timescale 1ns/1ps
`default_nettype none

module rab_cfg_asserts (
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic awready_i,
  input logic wr_en_i
);

  // Responses hold until the master takes them
  bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  aw_stall: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i |-> !awready_i)
    else $error("awready high while a write response is pending");

  wr_pulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_en_i |=> !wr_en_i)
    else $error("internal write pulse longer than one cycle");

endmodule

bind rab_cfg_top rab_cfg_asserts cfg_asserts_i (
  .Clk_CI    ( Clk_CI          ),
  .Rst_RBI   ( Rst_RBI         ),
  .bvalid_i  ( s_axi_bvalid_o  ),
  .bready_i  ( s_axi_bready_i  ),
  .rvalid_i  ( s_axi_rvalid_o  ),
  .rready_i  ( s_axi_rready_i  ),
  .awready_i ( s_axi_awready_o ),
  .wr_en_i   ( wr_en           )
);

`default_nettype wire

// File: rab_cfg_pkg.sv
// RAB configuration slave types
// Bus words, word indices and the decoded read word of the miss windows

`default_nettype none

package rab_cfg_pkg;

`include "rab_cfg_settings.svh"

  typedef logic [`RAB_AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`RAB_AXI_DATA_W-1:0]   cfg_word_t;
  typedef logic [`RAB_AXI_DATA_W/8-1:0] cfg_strb_t;
  typedef logic [`RAB_WORD_IDX_W-1:0]   word_idx_t;
  typedef logic [`RAB_ADDR_W_VIRT-1:0]  virt_addr_t;
  typedef logic [`RAB_MISS_ID_W-1:0]    miss_id_t;

  // Status word of a miss window
  typedef struct packed {
    logic                                            empty;  // FIFO holds nothing
    logic [`RAB_AXI_DATA_W-2-`RAB_ADDR_W_VIRT:0]     rsvd;
    virt_addr_t                                      head;   // IDs are zero-extended
  } mh_status_t;

  // Same read word, seen as slice data or as FIFO status
  typedef union packed {
    cfg_word_t  cfg;
    mh_status_t mh;
  } rd_word_u;

endpackage

`default_nettype wire

// File: rab_cfg_settings.svh
// RAB configuration slave sizes
// Word map, bus widths and miss FIFO depth shared by the design and testbench

`ifndef RAB_CFG_SETTINGS_SVH
`define RAB_CFG_SETTINGS_SVH

// L1 slices, each four 64-bit slots
`define RAB_N_SLICES         8
`define RAB_SLOTS_PER_SLICE  4
`define RAB_N_WORDS          36  // reserved slice plus the L1 slices
`define RAB_WORD_IDX_W       6

`define RAB_AXI_ADDR_W       32
`define RAB_AXI_DATA_W       64

`define RAB_ADDR_W_VIRT      32
`define RAB_ADDR_W_PHYS      40
`define RAB_N_FLAGS          4
`define RAB_MISS_ID_W        10
`define RAB_MH_FIFO_DEPTH    16

`define RAB_WORD_LSB         3   // byte offset inside a 64-bit word
`define RAB_MH_ADDR_WORD     0   // miss address window
`define RAB_MH_ID_WORD       1   // miss ID window

`endif

// File: rab_cfg_top.f
+incdir+.
rab_cfg_pkg.sv
rab_mh_fifo.sv
rab_axil_slave.sv
rab_l1_cfg_regs.sv
rab_miss_handler.sv
rab_cfg_top.sv
rab_cfg_asserts.sv
tb_rab_cfg.sv

// File: rab_cfg_top.sv
// RAB configuration and miss handling slave
// AXI4-Lite slave feeding the L1 slice registers and the miss FIFOs

`timescale 1ns/1ps
`default_nettype none

`include "rab_cfg_settings.svh"

module rab_cfg_top
  import rab_cfg_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  axi_addr_t  s_axi_awaddr_i,
  input  logic       s_axi_awvalid_i,
  output logic       s_axi_awready_o,
  input  cfg_word_t  s_axi_wdata_i,
  input  cfg_strb_t  s_axi_wstrb_i,
  input  logic       s_axi_wvalid_i,
  output logic       s_axi_wready_o,
  output logic [1:0] s_axi_bresp_o,
  output logic       s_axi_bvalid_o,
  input  logic       s_axi_bready_i,
  input  axi_addr_t  s_axi_araddr_i,
  input  logic       s_axi_arvalid_i,
  output logic       s_axi_arready_o,
  output cfg_word_t  s_axi_rdata_o,
  output logic [1:0] s_axi_rresp_o,
  output logic       s_axi_rvalid_o,
  input  logic       s_axi_rready_i,
  output cfg_word_t [`RAB_N_SLICES*`RAB_SLOTS_PER_SLICE-1:0] l1_cfg_o,
  input  logic       miss_i,
  input  virt_addr_t miss_addr_i,
  input  miss_id_t   miss_id_i,
  output logic       mh_fifo_full_o
);

  logic      wr_en, rd_pop;
  word_idx_t wr_idx, rd_idx;
  cfg_word_t wr_data, regs_rdata, mh_rdata;
  cfg_strb_t wr_strb;

  rab_axil_slave axil_slave_i (
    .Clk_CI          ( Clk_CI          ),
    .Rst_RBI         ( Rst_RBI         ),
    .s_axi_awaddr_i  ( s_axi_awaddr_i  ),
    .s_axi_awvalid_i ( s_axi_awvalid_i ),
    .s_axi_awready_o ( s_axi_awready_o ),
    .s_axi_wdata_i   ( s_axi_wdata_i   ),
    .s_axi_wstrb_i   ( s_axi_wstrb_i   ),
    .s_axi_wvalid_i  ( s_axi_wvalid_i  ),
    .s_axi_wready_o  ( s_axi_wready_o  ),
    .s_axi_bresp_o   ( s_axi_bresp_o   ),
    .s_axi_bvalid_o  ( s_axi_bvalid_o  ),
    .s_axi_bready_i  ( s_axi_bready_i  ),
    .s_axi_araddr_i  ( s_axi_araddr_i  ),
    .s_axi_arvalid_i ( s_axi_arvalid_i ),
    .s_axi_arready_o ( s_axi_arready_o ),
    .s_axi_rdata_o   ( s_axi_rdata_o   ),
    .s_axi_rresp_o   ( s_axi_rresp_o   ),
    .s_axi_rvalid_o  ( s_axi_rvalid_o  ),
    .s_axi_rready_i  ( s_axi_rready_i  ),
    .wr_en_o         ( wr_en           ),
    .wr_idx_o        ( wr_idx          ),
    .wr_data_o       ( wr_data         ),
    .wr_strb_o       ( wr_strb         ),
    .rd_idx_o        ( rd_idx          ),
    .rd_pop_o        ( rd_pop          ),
    .regs_rdata_i    ( regs_rdata      ),
    .mh_rdata_i      ( mh_rdata        )
  );

  rab_l1_cfg_regs l1_cfg_regs_i (
    .Clk_CI    ( Clk_CI     ),
    .Rst_RBI   ( Rst_RBI    ),
    .wr_en_i   ( wr_en      ),
    .wr_idx_i  ( wr_idx     ),
    .wr_data_i ( wr_data    ),
    .wr_strb_i ( wr_strb    ),
    .rd_idx_i  ( rd_idx     ),
    .rdata_o   ( regs_rdata ),
    .l1_cfg_o  ( l1_cfg_o   )
  );

  rab_miss_handler miss_handler_i (
    .Clk_CI         ( Clk_CI         ),
    .Rst_RBI        ( Rst_RBI        ),
    .miss_i         ( miss_i         ),
    .miss_addr_i    ( miss_addr_i    ),
    .miss_id_i      ( miss_id_i      ),
    .wr_en_i        ( wr_en          ),
    .wr_idx_i       ( wr_idx         ),
    .wr_data_i      ( wr_data        ),
    .rd_idx_i       ( rd_idx         ),
    .rd_pop_i       ( rd_pop         ),
    .rdata_o        ( mh_rdata       ),
    .mh_fifo_full_o ( mh_fifo_full_o )
  );

endmodule

`default_nettype wire

// File: rab_l1_cfg_regs.sv
// RAB L1 slice configuration registers
// Stores strobed bytes of each slot, masked to the address or flag width of
// the slot, and drives all slice words outward

`timescale 1ns/1ps
`default_nettype none

`include "rab_cfg_settings.svh"

module rab_l1_cfg_regs
  import rab_cfg_pkg::*;
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  logic      wr_en_i,
  input  word_idx_t wr_idx_i,
  input  cfg_word_t wr_data_i,
  input  cfg_strb_t wr_strb_i,
  input  word_idx_t rd_idx_i,
  output cfg_word_t rdata_o,
  output cfg_word_t [`RAB_N_SLICES*`RAB_SLOTS_PER_SLICE-1:0] l1_cfg_o
);

  localparam int unsigned N_CFG = `RAB_N_SLICES * `RAB_SLOTS_PER_SLICE;
  localparam int unsigned POS_W = $clog2(N_CFG);

  cfg_word_t [N_CFG-1:0] cfg_q;
  cfg_word_t             wr_word;
  logic                  wr_hit, rd_hit;
  logic [POS_W-1:0]      wr_pos, rd_pos;

  // Bits kept per slot: two virtual address slots, one physical, one flags
  function automatic cfg_word_t slot_mask(input logic [1:0] slot);
    cfg_word_t mask;
    mask = '0;
    case (slot)
      2'd0, 2'd1: mask[`RAB_ADDR_W_VIRT-1:0] = '1;
      2'd2:       mask[`RAB_ADDR_W_PHYS-1:0] = '1;
      default:    mask[`RAB_N_FLAGS-1:0]     = '1;
    endcase
    return mask;
  endfunction

  // First slice of the map is reserved
  assign wr_hit = (wr_idx_i >= word_idx_t'(`RAB_SLOTS_PER_SLICE)) &&
                  (wr_idx_i <  word_idx_t'(`RAB_N_WORDS));
  assign rd_hit = (rd_idx_i >= word_idx_t'(`RAB_SLOTS_PER_SLICE)) &&
                  (rd_idx_i <  word_idx_t'(`RAB_N_WORDS));
  assign wr_pos = POS_W'(wr_idx_i - word_idx_t'(`RAB_SLOTS_PER_SLICE));
  assign rd_pos = POS_W'(rd_idx_i - word_idx_t'(`RAB_SLOTS_PER_SLICE));

  // Unstrobed bytes are cleared
  always_comb
  begin
    for (int b = 0; b < `RAB_AXI_DATA_W/8; b++)
      wr_word[8*b +: 8] = wr_strb_i[b] ? wr_data_i[8*b +: 8] : 8'h00;
    wr_word = wr_word & slot_mask(wr_idx_i[1:0]);  // slot within slice
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      cfg_q <= '0;
    end
    else if (wr_en_i && wr_hit)
    begin
      cfg_q[wr_pos] <= wr_word;
    end
  end

  assign rdata_o  = rd_hit ? cfg_q[rd_pos] : '0;
  assign l1_cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: rab_mh_fifo.sv
// Miss handling FIFO
// Circular buffer with a head output; pushes when full and pops when empty
// are dropped

`timescale 1ns/1ps
`default_nettype none

module rab_mh_fifo #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 16
) (
  input  logic              Clk_CI,
  input  logic              Rst_RBI,
  input  logic              push_i,
  input  logic [DATA_W-1:0] push_data_i,
  input  logic              pop_i,
  output logic [DATA_W-1:0] head_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push_ok, pop_ok;

  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_ok)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push_ok && !pop_ok)
        count_q <= count_q + 1'b1;
      else if (pop_ok && !push_ok)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (push_ok)
      mem_q[wr_ptr_q] <= push_data_i;
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

// File: rab_miss_handler.sv
// RAB miss handler
// Logs missed virtual addresses and IDs into two FIFOs, lets software push
// and pop them through the two miss windows and forms the status read word

`timescale 1ns/1ps
`default_nettype none

`include "rab_cfg_settings.svh"

module rab_miss_handler
  import rab_cfg_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  logic       miss_i,
  input  virt_addr_t miss_addr_i,
  input  miss_id_t   miss_id_i,
  input  logic       wr_en_i,
  input  word_idx_t  wr_idx_i,
  input  cfg_word_t  wr_data_i,
  input  word_idx_t  rd_idx_i,
  input  logic       rd_pop_i,
  output cfg_word_t  rdata_o,
  output logic       mh_fifo_full_o
);

  logic       addr_push, id_push;
  virt_addr_t addr_din;
  miss_id_t   id_din;
  logic       addr_pop, id_pop;
  virt_addr_t addr_head;
  miss_id_t   id_head;
  logic       addr_full, addr_empty;
  logic       id_full, id_empty;
  logic       rd_addr_win, rd_id_win;
  rd_word_u   rd_word;

  assign rd_addr_win = (rd_idx_i == word_idx_t'(`RAB_MH_ADDR_WORD));
  assign rd_id_win   = (rd_idx_i == word_idx_t'(`RAB_MH_ID_WORD));

  // A miss wins over a software push in the same cycle
  assign addr_push = miss_i | (wr_en_i && wr_idx_i == word_idx_t'(`RAB_MH_ADDR_WORD));
  assign id_push   = miss_i | (wr_en_i && wr_idx_i == word_idx_t'(`RAB_MH_ID_WORD));
  assign addr_din  = miss_i ? miss_addr_i : virt_addr_t'(wr_data_i);
  assign id_din    = miss_i ? miss_id_i : miss_id_t'(wr_data_i);

  assign mh_fifo_full_o = (addr_push & addr_full) | (id_push & id_full);

  // Pop only what the read actually returned
  assign addr_pop = rd_pop_i & rd_addr_win & ~addr_empty;
  assign id_pop   = rd_pop_i & rd_id_win & ~id_empty;

  always_comb
  begin
    rd_word.cfg = '0;
    if (rd_addr_win)
    begin
      rd_word.mh.empty = addr_empty;
      rd_word.mh.head  = addr_head;
    end
    else if (rd_id_win)
    begin
      rd_word.mh.empty = id_empty;
      rd_word.mh.head  = virt_addr_t'(id_head);  // zero-extended
    end
  end

  assign rdata_o = rd_word.cfg;

  rab_mh_fifo #(
    .DATA_W ( `RAB_ADDR_W_VIRT   ),
    .DEPTH  ( `RAB_MH_FIFO_DEPTH )
  ) addr_fifo_i (
    .Clk_CI      ( Clk_CI     ),
    .Rst_RBI     ( Rst_RBI    ),
    .push_i      ( addr_push  ),
    .push_data_i ( addr_din   ),
    .pop_i       ( addr_pop   ),
    .head_o      ( addr_head  ),
    .full_o      ( addr_full  ),
    .empty_o     ( addr_empty )
  );

  rab_mh_fifo #(
    .DATA_W ( `RAB_MISS_ID_W     ),
    .DEPTH  ( `RAB_MH_FIFO_DEPTH )
  ) id_fifo_i (
    .Clk_CI      ( Clk_CI   ),
    .Rst_RBI     ( Rst_RBI  ),
    .push_i      ( id_push  ),
    .push_data_i ( id_din   ),
    .pop_i       ( id_pop   ),
    .head_o      ( id_head  ),
    .full_o      ( id_full  ),
    .empty_o     ( id_empty )
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the RAB configuration slave testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f rab_cfg_top.f --top-module tb_rab_cfg -o tb_rab_cfg
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_rab_cfg > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: tb_rab_cfg.sv
// RAB configuration slave testbench
// Directed tests of slice masking, byte strobes, miss FIFOs and AXI back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "rab_cfg_settings.svh"

module tb_rab_cfg
  import rab_cfg_pkg::*;
();

  localparam int          PERIOD    = 100;
  localparam int          N_CFG     = `RAB_N_SLICES * `RAB_SLOTS_PER_SLICE;
  localparam int          DEPTH     = `RAB_MH_FIFO_DEPTH;
  localparam int          N_TRANS   = 200;  // AXI transfers and miss pulses, all tests
  localparam int          WD_CYCLES = N_TRANS * 40 + 2000;
  localparam int unsigned SEED      = 32'hbbb2_c139;
  localparam logic [1:0]  RESP_OKAY = 2'b00;

  logic       Clk_CI = 1'b0;
  logic       Rst_RBI;
  axi_addr_t  s_axi_awaddr, s_axi_araddr;
  logic       s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  cfg_word_t  s_axi_wdata, s_axi_rdata;
  cfg_strb_t  s_axi_wstrb;
  logic [1:0] s_axi_bresp, s_axi_rresp;
  logic       s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic       s_axi_rvalid, s_axi_rready;
  cfg_word_t [N_CFG-1:0] l1_cfg_o;
  logic       miss_i, mh_fifo_full_o;
  virt_addr_t miss_addr_i;
  miss_id_t   miss_id_i;

  // Reference model of the slice words and the two miss FIFOs
  cfg_word_t  exp_cfg [N_CFG];
  virt_addr_t exp_addr_q [$];
  miss_id_t   exp_id_q [$];
  int         errors = 0;
  int         checks = 0;

  always #(PERIOD/2) Clk_CI = ~Clk_CI;

  rab_cfg_top rab_cfg_top_i (
    .Clk_CI (Clk_CI), .Rst_RBI (Rst_RBI),
    .s_axi_awaddr_i (s_axi_awaddr), .s_axi_awvalid_i (s_axi_awvalid),
    .s_axi_awready_o (s_axi_awready), .s_axi_wdata_i (s_axi_wdata),
    .s_axi_wstrb_i (s_axi_wstrb), .s_axi_wvalid_i (s_axi_wvalid),
    .s_axi_wready_o (s_axi_wready), .s_axi_bresp_o (s_axi_bresp),
    .s_axi_bvalid_o (s_axi_bvalid), .s_axi_bready_i (s_axi_bready),
    .s_axi_araddr_i (s_axi_araddr), .s_axi_arvalid_i (s_axi_arvalid),
    .s_axi_arready_o (s_axi_arready), .s_axi_rdata_o (s_axi_rdata),
    .s_axi_rresp_o (s_axi_rresp), .s_axi_rvalid_o (s_axi_rvalid),
    .s_axi_rready_i (s_axi_rready), .l1_cfg_o (l1_cfg_o),
    .miss_i (miss_i), .miss_addr_i (miss_addr_i), .miss_id_i (miss_id_i),
    .mh_fifo_full_o (mh_fifo_full_o)
  );

  // Virtual slots keep 32 bits, the physical slot 40, the flags slot 4
  function automatic cfg_word_t kept_bits(input int word);
    case (word % 4)
      0, 1:    return {{(64-`RAB_ADDR_W_VIRT){1'b0}}, {`RAB_ADDR_W_VIRT{1'b1}}};
      2:       return {{(64-`RAB_ADDR_W_PHYS){1'b0}}, {`RAB_ADDR_W_PHYS{1'b1}}};
      default: return {{(64-`RAB_N_FLAGS){1'b0}}, {`RAB_N_FLAGS{1'b1}}};
    endcase
  endfunction

  function automatic cfg_word_t strobed(input cfg_word_t data, input cfg_strb_t strb);
    cfg_word_t res;
    res = '0;
    for (int b = 0; b < 8; b++)
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    return res;
  endfunction

  function automatic axi_addr_t word_addr(input int word);
    return axi_addr_t'(word) << `RAB_WORD_LSB;
  endfunction

  function automatic cfg_word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // Head only matters while the FIFO holds something
  task automatic check_status(input string name, input rd_word_u got, input rd_word_u want);
    checks++;
    if (got.mh.empty !== want.mh.empty || (!want.mh.empty && got.mh.head !== want.mh.head))
    begin
      errors++;
      $display("Error %s: got 0x%h, expected 0x%h", name, got.cfg, want.cfg);
    end
  endtask

  // All tasks start and end on a falling edge
  task automatic axi_write(input axi_addr_t addr, input cfg_word_t data,
                           input cfg_strb_t strb, input int hold);
    int n;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    n = 0;
    while (!(s_axi_awready && s_axi_wready) && n < 20)
    begin
      @(negedge Clk_CI);
      n++;
    end
    @(negedge Clk_CI);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    while (!s_axi_bvalid && n < 20)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!s_axi_bvalid)
      report_failure($sformatf("Write to 0x%h got no response", addr));
    else
      check_resp("s_axi_bresp", s_axi_bresp, RESP_OKAY);
    repeat (hold)
    begin
      @(negedge Clk_CI);
      check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);  // held by low bready
    end
    s_axi_bready = 1'b1;
    @(negedge Clk_CI);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, input int hold, output cfg_word_t data);
    int n;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    n = 0;
    while (!s_axi_arready && n < 20)
    begin
      @(negedge Clk_CI);
      n++;
    end
    @(negedge Clk_CI);
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid && n < 20)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!s_axi_rvalid)
      report_failure($sformatf("Read of 0x%h returned no data", addr));
    repeat (hold)
    begin
      @(negedge Clk_CI);
      check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
    end
    data = s_axi_rdata;
    if (s_axi_rvalid)
      check_resp("s_axi_rresp", s_axi_rresp, RESP_OKAY);
    s_axi_rready = 1'b1;
    @(negedge Clk_CI);
    s_axi_rready = 1'b0;
  endtask

  task automatic miss_pulse(input virt_addr_t addr, input miss_id_t id);
    logic want_full;
    want_full = (exp_addr_q.size() == DEPTH) || (exp_id_q.size() == DEPTH);
    miss_i      = 1'b1;
    miss_addr_i = addr;
    miss_id_i   = id;
    #(PERIOD/4);  // full flag settled well before the rising edge
    check_bit("mh_fifo_full_o", mh_fifo_full_o, want_full);
    @(negedge Clk_CI);
    miss_i = 1'b0;
    if (exp_addr_q.size() < DEPTH)
      exp_addr_q.push_back(addr);
    if (exp_id_q.size() < DEPTH)
      exp_id_q.push_back(id);
  endtask

  // Reads a miss window and pops the model on a non-empty FIFO
  task automatic read_window(input int word);
    cfg_word_t rd;
    rd_word_u  want;
    want.cfg = '0;
    if (word == `RAB_MH_ADDR_WORD)
    begin
      want.mh.empty = (exp_addr_q.size() == 0);
      if (!want.mh.empty)
        want.mh.head = exp_addr_q.pop_front();
    end
    else
    begin
      want.mh.empty = (exp_id_q.size() == 0);
      if (!want.mh.empty)
        want.mh.head = virt_addr_t'(exp_id_q.pop_front());
    end
    axi_read(word_addr(word), 0, rd);
    check_status($sformatf("s_axi_rdata word %0d", word), rd, want);
  endtask

  task automatic write_slice(input int word, input cfg_word_t data, input cfg_strb_t strb,
                             input int hold);
    axi_write(word_addr(word), data, strb, hold);
    exp_cfg[word-4] = strobed(data, strb) & kept_bits(word);
  endtask

  task automatic read_slice(input int word, input int hold);
    cfg_word_t rd;
    axi_read(word_addr(word), hold, rd);
    check_word($sformatf("s_axi_rdata word %0d", word), rd, exp_cfg[word-4]);
  endtask

  task automatic check_l1_out();
    for (int i = 0; i < N_CFG; i++)
      check_word($sformatf("l1_cfg_o[%0d]", i), l1_cfg_o[i], exp_cfg[i]);
  endtask

  task automatic test_reset();
    check_bit("s_axi_awready", s_axi_awready, 1'b1);
    check_bit("s_axi_wready", s_axi_wready, 1'b1);
    check_bit("s_axi_arready", s_axi_arready, 1'b1);
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_l1_out();
    read_window(`RAB_MH_ADDR_WORD);
    read_window(`RAB_MH_ID_WORD);
  endtask

  task automatic test_slot_masking();
    for (int w = 4; w < `RAB_N_WORDS; w++)
      write_slice(w, rand_word(), 8'hff, 0);
    for (int w = 4; w < `RAB_N_WORDS; w++)
      read_slice(w, 0);
    check_l1_out();
  endtask

  // Full write first, so cleared bytes really held data
  task automatic test_byte_strobes();
    int w;
    repeat (8)
    begin
      w = 4 + int'($urandom_range(31, 0));
      write_slice(w, rand_word(), 8'hff, 0);
      write_slice(w, rand_word(), cfg_strb_t'($urandom()), 0);
      read_slice(w, 0);
    end
    check_l1_out();
  endtask

  task automatic test_miss_logging();
    cfg_word_t data;
    int        n;
    for (int i = 0; i < 6; i++)
      miss_pulse(virt_addr_t'($urandom()), miss_id_t'($urandom()));
    for (int i = 0; i < 3; i++)
    begin
      data = rand_word();
      axi_write(word_addr(`RAB_MH_ADDR_WORD), data, 8'hff, 0);
      exp_addr_q.push_back(virt_addr_t'(data));
    end
    for (int i = 0; i < 2; i++)
    begin
      data = rand_word();
      axi_write(word_addr(`RAB_MH_ID_WORD), data, 8'hff, 0);
      exp_id_q.push_back(miss_id_t'(data));
    end
    n = exp_addr_q.size();
    repeat (n + 1)
      read_window(`RAB_MH_ADDR_WORD);  // last read sees the empty flag
    n = exp_id_q.size();
    repeat (n + 1)
      read_window(`RAB_MH_ID_WORD);
  endtask

  task automatic test_overflow();
    for (int i = 0; i < DEPTH + 1; i++)
      miss_pulse(virt_addr_t'($urandom()), miss_id_t'($urandom()));
    repeat (DEPTH + 1)
      read_window(`RAB_MH_ADDR_WORD);
    repeat (DEPTH + 1)
      read_window(`RAB_MH_ID_WORD);
  endtask

  task automatic test_backpressure_reserved();
    axi_addr_t rsvd [5];
    cfg_word_t rd;
    int        w;
    rsvd = '{word_addr(2), word_addr(3), word_addr(40), 32'h0000_0200, 32'h0000_1008};
    repeat (6)
    begin
      w = 4 + int'($urandom_range(31, 0));
      write_slice(w, rand_word(), 8'hff, int'($urandom_range(8, 1)));
      read_slice(w, int'($urandom_range(8, 1)));
    end
    foreach (rsvd[i])
    begin
      axi_write(rsvd[i], rand_word(), 8'hff, 0);
      axi_read(rsvd[i], 0, rd);
      check_word($sformatf("s_axi_rdata at 0x%h", rsvd[i]), rd, '0);
    end
    check_l1_out();
    read_window(`RAB_MH_ADDR_WORD);  // aliased address must not push
    read_window(`RAB_MH_ID_WORD);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before)
      $display("%s: passed", name);
    else
      $display("%s: %0d errors", name, errors - errors_before);
  endtask

  initial
  begin
    int mark;
    void'($urandom(SEED));
    Rst_RBI       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    miss_i        = 1'b0;
    miss_addr_i   = '0;
    miss_id_i     = '0;
    foreach (exp_cfg[i])
      exp_cfg[i] = '0;
    repeat (10) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);

    mark = errors;
    test_reset();
    report_test("reset", mark);
    mark = errors;
    test_slot_masking();
    report_test("slot masking", mark);
    mark = errors;
    test_byte_strobes();
    report_test("byte strobes", mark);
    mark = errors;
    test_miss_logging();
    report_test("miss logging", mark);
    mark = errors;
    test_overflow();
    report_test("overflow", mark);
    mark = errors;
    test_backpressure_reserved();
    report_test("back-pressure and reserved space", mark);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge Clk_CI);
    $display("Timeout after %0d cycles, tests did not finish", WD_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
